// ==== common/b1Pkg.sv ====
`default_nettype none

package b1Pkg;

	// Line buffer geometry
	localparam int LB_ADDR_W = 8;		// 256 entries per buffer
	localparam int LB_DATA_W = 12;		// Palette 8 bits over colour 4 bits

	// Palette RAM address width
	localparam int PA_W = 12;

	// Watchdog timing in CLK_SPR_PAL cycles
	localparam int WDG_LIMIT = 3000;	// Cycles without kick before firing
	localparam int WDG_PULSE = 16;		// Length of the nReset/nHalt pulse

	// Address bits 21..17 of the watchdog register, $300000 region
	localparam logic [4:0] WDG_KICK_U = 5'b11000;

	// Watchdog FSM
	typedef enum logic
	{
		wdRun,		// Counting towards timeout
		wdFire		// Driving the reset pulse
	} wdState_e;

	// Palette address source, listed in priority order
	typedef enum logic [1:0]
	{
		srcCpu,		// 68k palette RAM access
		srcBlank,	// Horizontal blanking
		srcFix,		// Opaque fix layer pixel
		srcSpr		// Line buffer output
	} paSrc_e;

endpackage

`default_nettype wire

// ==== lineBuffer/lineBuffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lineBuffer
	import b1Pkg::*;
(
	input  wire                  CLK_SPR_PAL,
	input  wire                  rstN,
	input  wire                  ld,		// Load write counter
	input  wire                  inc,		// Step write counter
	input  wire [LB_ADDR_W-1:0]  ldAddr,
	input  wire                  we,
	input  wire [LB_DATA_W-1:0]  wData,
	input  wire                  rdClr,		// Clear entry at rdAddr
	input  wire                  rdInc,		// Read slot for this buffer
	input  wire [LB_ADDR_W-1:0]  rdAddr,
	output logic [LB_DATA_W-1:0] rData
);

	logic [LB_DATA_W-1:0]      mem [0:(1<<LB_ADDR_W)-1];
	logic [(1<<LB_ADDR_W)-1:0] filled;		// Entry holds a pixel
	logic [LB_ADDR_W-1:0]      wrCnt;
	logic                      opaque;

	// Colour 0 is transparent, entry keeps its old contents
	assign opaque = |wData[3:0];

	// Write counter, load wins over step
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
			wrCnt <= '0;
		else if (ld)
			wrCnt <= ldAddr;
		else if (inc)
			wrCnt <= wrCnt + 1'b1;
	end

	// Pixel storage
	always_ff @(posedge CLK_SPR_PAL)
	begin
		if (we && opaque)
			mem[wrCnt] <= wData;
	end

	// Per-entry flags
	// A cleared entry reads back as zero
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
			filled <= '0;
		else
		begin
			if (we && opaque)
				filled[wrCnt] <= 1'b1;
			if (rdClr)
				filled[rdAddr] <= 1'b0;	// Never same buffer as a write
		end
	end

	// Registered read port, old value seen on a clearing read
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
			rData <= '0;
		else if (rdInc)
			rData <= filled[rdAddr] ? mem[rdAddr] : '0;
	end

endmodule

`default_nettype wire

// ==== lineBuffer/lineBufferBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module lineBufferBank
	import b1Pkg::*;
(
	input  wire                  CLK_SPR_PAL,
	input  wire                  rstN,
	input  wire                  tms0,		// High means A renders, B displays
	input  wire                  ldPos,
	input  wire                  palLd,
	input  wire                  pixWe,
	input  wire                  lineStart,
	input  wire                  dispEn,
	input  wire [23:0]           pbus,
	input  wire [3:0]            gad,		// Even pixel colour
	input  wire [3:0]            gbd,		// Odd pixel colour
	output logic [LB_DATA_W-1:0] sprData,
	output logic                 evenSlot
);

	logic [7:0]           sprPal;
	logic [LB_ADDR_W-1:0] rdCnt;
	logic                 oddPhase;		// Next slot is odd
	logic                 oddSlot;
	logic                 oddD;			// Parity of the slot behind sprData
	logic                 showAD;		// Pair A was displayed in that slot
	logic                 ldA, ldB, wrA, wrB;
	logic                 rdEvenA, rdEvenB, clrA, clrB;
	logic [LB_DATA_W-1:0] evenWData, oddWData;
	logic [LB_DATA_W-1:0] evenAData, oddAData, evenBData, oddBData;

	assign evenSlot = dispEn && !oddPhase;
	assign oddSlot  = dispEn && oddPhase;

	assign evenWData = {sprPal, gad};
	assign oddWData  = {sprPal, gbd};

	// Render side gets loads and writes
	assign ldA = ldPos && tms0;
	assign ldB = ldPos && !tms0;
	assign wrA = pixWe && tms0;
	assign wrB = pixWe && !tms0;

	// Display side gets reads, odd slot reads odd and clears both
	assign rdEvenA = evenSlot && !tms0;
	assign rdEvenB = evenSlot && tms0;
	assign clrA    = oddSlot && !tms0;
	assign clrB    = oddSlot && tms0;

	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
		begin
			sprPal   <= '0;
			rdCnt    <= '0;
			oddPhase <= 1'b0;
			oddD     <= 1'b0;
			showAD   <= 1'b0;
		end
		else
		begin
			if (palLd)
				sprPal <= pbus[23:16];	// Sprite palette off the P bus
			if (lineStart)
			begin
				rdCnt    <= '0;
				oddPhase <= 1'b0;		// First slot of a line is even
			end
			else if (dispEn)
			begin
				oddPhase <= !oddPhase;
				if (oddPhase)
					rdCnt <= rdCnt + 1'b1;	// Step after the pixel pair
			end
			if (dispEn)
			begin
				oddD   <= oddPhase;
				showAD <= !tms0;
			end
		end
	end

	lineBuffer evenA (.CLK_SPR_PAL, .rstN, .ld(ldA), .inc(wrA), .ldAddr(pbus[7:0]),
		.we(wrA), .wData(evenWData), .rdClr(clrA), .rdInc(rdEvenA), .rdAddr(rdCnt),
		.rData(evenAData));
	lineBuffer oddA (.CLK_SPR_PAL, .rstN, .ld(ldA), .inc(wrA), .ldAddr(pbus[7:0]),
		.we(wrA), .wData(oddWData), .rdClr(clrA), .rdInc(clrA), .rdAddr(rdCnt),
		.rData(oddAData));
	lineBuffer evenB (.CLK_SPR_PAL, .rstN, .ld(ldB), .inc(wrB), .ldAddr(pbus[7:0]),
		.we(wrB), .wData(evenWData), .rdClr(clrB), .rdInc(rdEvenB), .rdAddr(rdCnt),
		.rData(evenBData));
	lineBuffer oddB (.CLK_SPR_PAL, .rstN, .ld(ldB), .inc(wrB), .ldAddr(pbus[7:0]),
		.we(wrB), .wData(oddWData), .rdClr(clrB), .rdInc(clrB), .rdAddr(rdCnt),
		.rData(oddBData));

	// Displayed pair and parity, both one cycle behind the slot
	assign sprData = showAD ? (oddD ? oddAData : evenAData)
	                        : (oddD ? oddBData : evenBData);

endmodule

`default_nettype wire

// ==== logic/fixPixelLatch.sv ====
`timescale 1ns/1ns
`default_nettype none

module fixPixelLatch
	import b1Pkg::*;
(
	input  wire        CLK_SPR_PAL,
	input  wire        rstN,
	input  wire        fixLd,
	input  wire        evenSlot,	// From the line buffer bank
	input  wire        dispEn,
	input  wire [7:0]  fixd,		// Two interleaved 4-bit pixels
	input  wire [3:0]  fixPal,
	output logic [3:0] fixColor,
	output logic [3:0] fixPalOut
);

	logic [7:0] stageA;
	logic [7:0] stageB;
	logic [3:0] palReg;
	logic       oddD;		// Parity of the slot being shown

	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
		begin
			stageA <= '0;
			stageB <= '0;
			palReg <= '0;
			oddD   <= 1'b0;
		end
		else
		begin
			if (fixLd)
			begin
				stageA <= fixd;
				palReg <= fixPal;
			end
			if (evenSlot)
				stageB <= stageA;	// New tile pair at each even slot
			if (dispEn)
				oddD <= !evenSlot;
		end
	end

	// Odd/even nibble demux
	// Even pixel on the even bits
	assign fixColor = oddD ? {stageB[7], stageB[5], stageB[3], stageB[1]}
	                       : {stageB[6], stageB[4], stageB[2], stageB[0]};

	assign fixPalOut = palReg;

endmodule

`default_nettype wire

// ==== logic/paletteAddressMux.sv ====
`timescale 1ns/1ns
`default_nettype none

module paletteAddressMux
	import b1Pkg::*;
(
	input  wire                  CLK_SPR_PAL,
	input  wire                  rstN,
	input  wire                  nAs,
	input  wire                  a23z,
	input  wire                  a22z,
	input  wire                  chbl,
	input  wire [12:1]           m68kAddrL,
	input  wire [3:0]            fixColor,
	input  wire [3:0]            fixPal,
	input  wire [LB_DATA_W-1:0]  sprData,
	output logic [PA_W-1:0]      pa
);

	paSrc_e src;

	// Priority pick
	always_comb
	begin
		if (!nAs && !a23z && a22z)
			src = srcCpu;			// $400000 palette window
		else if (chbl)
			src = srcBlank;
		else if (|fixColor)
			src = srcFix;			// Non-zero fix colour is opaque
		else
			src = srcSpr;
	end

	// Palette RAM address register
	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
			pa <= '0;
		else
		begin
			case (src)
				srcCpu:   pa <= m68kAddrL;
				srcBlank: pa <= '0;
				srcFix:   pa <= {4'b0000, fixPal, fixColor};
				default:  pa <= sprData;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/watchdog.sv ====
`timescale 1ns/1ns
`default_nettype none

module watchdog
	import b1Pkg::*;
(
	input  wire        CLK_SPR_PAL,
	input  wire        rstN,
	input  wire        nAs,
	input  wire        nLds,
	input  wire        rw,
	input  wire        a23z,
	input  wire        a22z,
	input  wire [21:17] m68kAddrU,
	output logic       nHalt,
	output logic       nReset
);

	typedef logic [$clog2(WDG_LIMIT)-1:0] toCnt_t;
	typedef logic [$clog2(WDG_PULSE)-1:0] pulseCnt_t;

	wdState_e  state;
	toCnt_t    toCnt;		// Cycles since last kick
	pulseCnt_t pulseCnt;	// Cycles into the reset pulse
	logic      kick;

	// Lower byte write to $300000 region
	assign kick = !nAs && !nLds && !rw && !a23z && !a22z && (m68kAddrU == WDG_KICK_U);

	always_ff @(posedge CLK_SPR_PAL or negedge rstN)
	begin
		if (!rstN)
		begin
			state    <= wdRun;
			toCnt    <= '0;
			pulseCnt <= '0;
		end
		else
		begin
			case (state)
				wdRun:
				begin
					if (kick)
						toCnt <= '0;
					else if (toCnt == toCnt_t'(WDG_LIMIT - 1))
					begin
						state    <= wdFire;		// Program stopped kicking
						toCnt    <= '0;
						pulseCnt <= '0;
					end
					else
						toCnt <= toCnt + 1'b1;
				end
				wdFire:
				begin
					// Kicks ignored while the pulse runs
					if (pulseCnt == pulseCnt_t'(WDG_PULSE - 1))
						state <= wdRun;			// Count restarts from zero
					else
						pulseCnt <= pulseCnt + 1'b1;
				end
				default: state <= wdRun;
			endcase
		end
	end

	assign nReset = (state != wdFire);
	assign nHalt  = (state != wdFire);	// Same pulse halts the CPU

endmodule

`default_nettype wire

// ==== logic/neoB1.sv ====
`timescale 1ns/1ns
`default_nettype none

module neoB1
	import b1Pkg::*;
(
	input  wire             CLK_SPR_PAL,
	input  wire             rstN,
	input  wire [23:0]      pbus,
	input  wire [7:0]       fixd,
	input  wire             fixLd,
	input  wire             chbl,
	input  wire [3:0]       gad,
	input  wire [3:0]       gbd,
	input  wire             tms0,		// Buffer pair flip
	input  wire             ldPos,
	input  wire             palLd,
	input  wire             pixWe,
	input  wire             lineStart,
	input  wire             dispEn,
	input  wire             a23z,
	input  wire             a22z,
	input  wire             nLds,
	input  wire             rw,
	input  wire             nAs,
	input  wire [21:17]     m68kAddrU,
	input  wire [12:1]      m68kAddrL,
	output logic [PA_W-1:0] pa,
	output logic            nHalt,
	output logic            nReset
);

	logic [LB_DATA_W-1:0] sprData;
	logic                 evenSlot;
	logic [3:0]           fixColor;
	logic [3:0]           fixPalOut;

	// Sprite line buffers
	lineBufferBank uBank (
		.CLK_SPR_PAL, .rstN, .tms0, .ldPos, .palLd, .pixWe, .lineStart, .dispEn,
		.pbus, .gad, .gbd,
		.sprData, .evenSlot
	);

	// Fix layer, palette rides on P bus bits 19..16
	fixPixelLatch uFix (
		.CLK_SPR_PAL, .rstN, .fixLd, .evenSlot, .dispEn,
		.fixd,
		.fixPal(pbus[19:16]),
		.fixColor, .fixPalOut
	);

	paletteAddressMux uPaMux (
		.CLK_SPR_PAL, .rstN, .nAs, .a23z, .a22z, .chbl,
		.m68kAddrL,
		.fixColor,
		.fixPal(fixPalOut),
		.sprData,
		.pa
	);

	watchdog uWdog (
		.CLK_SPR_PAL, .rstN, .nAs, .nLds, .rw, .a23z, .a22z,
		.m68kAddrU,
		.nHalt, .nReset
	);

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen
(
	output logic CLK_SPR_PAL,
	output logic rstN
);

	localparam int HALF_PERIOD  = 20;	// 40 ns clock
	localparam int RESET_CYCLES = 4;

	initial
	begin
		CLK_SPR_PAL = 1'b0;
		forever
			#HALF_PERIOD CLK_SPR_PAL = !CLK_SPR_PAL;
	end

	// Reset held over the first rising edges
	initial
	begin
		rstN = 1'b0;
		repeat (RESET_CYCLES)
			@(posedge CLK_SPR_PAL);
		@(negedge CLK_SPR_PAL);
		rstN = 1'b1;		// Released between edges
	end

endmodule

`default_nettype wire

// ==== dv/tbNeoB1.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbNeoB1
	import b1Pkg::*;
();

	wire                  CLK_SPR_PAL;
	wire                  rstN;
	logic [23:0]          pbus;
	logic [7:0]           fixd;
	logic [3:0]           gad, gbd;
	logic                 fixLd, chbl, tms0, ldPos, palLd, pixWe, lineStart, dispEn;
	logic                 a23z, a22z, nLds, rw, nAs;
	logic [21:17]         m68kAddrU;
	logic [12:1]          m68kAddrL;
	wire  [PA_W-1:0]      pa;
	wire                  nHalt, nReset;

	// Model state with pair 0 as A and pair 1 as B
	logic [LB_DATA_W-1:0] mMem [0:1][0:1][0:255];	// Zero marks an empty entry
	logic [7:0]           mWr [0:1];
	logic [7:0]           mPal, mRd, mFixA, mFixB;
	logic [3:0]           mFixPal;
	logic                 mOdd, mFixOdd, mFiring;
	logic [LB_DATA_W-1:0] mSpr;		// Last value read for display
	logic [PA_W-1:0]      mPa;
	int                   mWdCnt, mPulse;

	clockGen uClk (.CLK_SPR_PAL, .rstN);

	neoB1 DUT (.*);

	task automatic failRun();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, expected);
			failRun();
		end
	endtask

	task automatic resetModel();
		for (int p = 0; p < 2; p++)
			for (int o = 0; o < 2; o++)
				for (int a = 0; a < 256; a++)
					mMem[p][o][a] = '0;
		mWr[0] = '0;
		mWr[1] = '0;
		{mPal, mRd, mFixA, mFixB, mFixPal} = 36'd0;
		{mOdd, mFixOdd, mFiring} = 3'b000;
		mSpr   = '0;
		mPa    = '0;
		mWdCnt = 0;
		mPulse = 0;
	endtask

	// One clock of the reference model
	task automatic stepModel();
		logic [3:0] fixCol;
		paSrc_e     src;
		logic       dp;
		logic       rp;
		dp = tms0;		// tms0 high shows B
		rp = !tms0;
		fixCol = mFixOdd ? {mFixB[7], mFixB[5], mFixB[3], mFixB[1]}
		                 : {mFixB[6], mFixB[4], mFixB[2], mFixB[0]};
		if (!nAs && !a23z && a22z)
			src = srcCpu;
		else if (chbl)
			src = srcBlank;
		else if (fixCol != 4'd0)
			src = srcFix;
		else
			src = srcSpr;
		case (src)
			srcCpu:   mPa = m68kAddrL;
			srcBlank: mPa = '0;
			srcFix:   mPa = {4'b0000, mFixPal, fixCol};
			default:  mPa = mSpr;
		endcase
		if (dispEn)
		begin
			mFixOdd = mOdd;
			if (!mOdd)
			begin
				mSpr  = mMem[dp][0][mRd];
				mFixB = mFixA;		// Next fix pair
			end
			else
			begin
				mSpr = mMem[dp][1][mRd];
				mMem[dp][0][mRd] = '0;	// Cleared as read
				mMem[dp][1][mRd] = '0;
				mRd = mRd + 8'd1;
			end
			mOdd = !mOdd;
		end
		if (lineStart)
		begin
			mRd  = '0;
			mOdd = 1'b0;
		end
		if (pixWe)
		begin
			if (gad != 4'd0)
				mMem[rp][0][mWr[rp]] = {mPal, gad};
			if (gbd != 4'd0)
				mMem[rp][1][mWr[rp]] = {mPal, gbd};
			mWr[rp] = mWr[rp] + 8'd1;
		end
		if (ldPos)
			mWr[rp] = pbus[7:0];
		if (palLd)
			mPal = pbus[23:16];
		if (fixLd)
		begin
			mFixA   = fixd;
			mFixPal = pbus[19:16];
		end
		// Watchdog pulse ignores kicks
		if (mFiring)
		begin
			mPulse = mPulse - 1;
			mFiring = (mPulse != 0);
		end
		else if (!nAs && !nLds && !rw && !a23z && !a22z && m68kAddrU == WDG_KICK_U)
			mWdCnt = 0;
		else if (mWdCnt + 1 == WDG_LIMIT)
		begin
			mFiring = 1'b1;
			mPulse  = WDG_PULSE;
			mWdCnt  = 0;
		end
		else
			mWdCnt = mWdCnt + 1;
	endtask

	always @(posedge CLK_SPR_PAL)
	begin
		if (!rstN)
			resetModel();
		else
			stepModel();
	end

	// Advance one clock, check outputs, drop strobes
	task automatic nextCycle();
		@(posedge CLK_SPR_PAL);
		@(negedge CLK_SPR_PAL);
		compareValue("pa", 32'(pa), 32'(mPa));
		compareValue("nReset", 32'(nReset), 32'(!mFiring));
		compareValue("nHalt", 32'(nHalt), 32'(!mFiring));
		{ldPos, palLd, pixWe, lineStart, fixLd, chbl} = 6'b0;
		{nAs, nLds, rw, a23z, a22z} = 5'b11100;
	endtask

	function automatic logic [3:0] randomColor();
		if ($urandom_range(0, 3) == 0)
			return 4'd0;		// Transparent
		return 4'($urandom_range(1, 15));
	endfunction

	task automatic driveKick();
		{nAs, nLds, rw, a23z, a22z} = 5'b00000;
		m68kAddrU = WDG_KICK_U;
	endtask

	task automatic mixActivity(input bit writes, input bit fix, input bit cpu);
		int r;
		r = $urandom_range(0, 63);
		if (writes && r < 2)
		begin
			ldPos = 1'b1;
			pbus  = 24'($urandom());
		end
		else if (writes && r < 6)
		begin
			palLd = 1'b1;
			pbus  = 24'($urandom());
		end
		else if (writes && r < 40)
		begin
			pixWe = 1'b1;
			gad   = randomColor();
			gbd   = randomColor();
		end
		if (fix && $urandom_range(0, 7) == 0)
		begin
			fixLd       = 1'b1;
			fixd        = 8'($urandom() & $urandom());	// Sparse so some pixels stay clear
			pbus[19:16] = 4'($urandom());
		end
		if (cpu && $urandom_range(0, 5) == 0)
			chbl = 1'b1;
		if (cpu && $urandom_range(0, 5) == 0)
		begin
			nAs       = 1'b0;
			a22z      = 1'b1;		// Palette window
			m68kAddrL = 12'($urandom());
		end
		else if ($urandom_range(0, 63) == 0)
			driveKick();
	endtask

	// One full line of 256 pixel pairs
	task automatic displayLine(input bit writes, input bit fix, input bit cpu, input bit blank);
		bit          cpuNow;
		bit          blankNow;
		logic [12:1] addrNow;
		lineStart = 1'b1;
		nextCycle();
		dispEn = 1'b1;
		for (int i = 0; i < 512; i++)
		begin
			mixActivity(writes, fix, cpu);
			cpuNow   = !nAs && !a23z && a22z;
			blankNow = chbl;
			addrNow  = m68kAddrL;
			nextCycle();
			if (cpuNow)
				compareValue("pa", 32'(pa), 32'(addrNow));	// CPU beats blanking
			else if (blankNow || (blank && i >= 1))
				compareValue("pa", 32'(pa), 32'd0);
		end
		dispEn = 1'b0;
		repeat (2)
			nextCycle();
	endtask

	task automatic countUntilReset(input logic level, input int limit, output int count);
		count = 0;
		while (nReset !== level && count < limit)
		begin
			nextCycle();
			count++;
		end
		if (nReset !== level)
		begin
			$display("Timeout: nReset did not reach %0b within %0d cycles", level, limit);
			failRun();
		end
	endtask

	initial
	begin
		int waitCnt;
		void'($urandom(24));
		{pbus, fixd, gad, gbd} = 40'd0;
		{fixLd, chbl, ldPos, palLd, pixWe, lineStart, dispEn} = 7'b0;
		tms0 = 1'b1;
		{nAs, nLds, rw, a23z, a22z} = 5'b11100;
		m68kAddrU = '0;
		m68kAddrL = '0;
		waitCnt = 0;
		while (rstN !== 1'b1 && waitCnt < 20)
		begin
			@(negedge CLK_SPR_PAL);
			waitCnt++;
		end
		if (rstN !== 1'b1)
		begin
			$display("Reset was never released");
			failRun();
		end
		repeat (20)
		begin
			nextCycle();
			compareValue("pa", 32'(pa), 32'd0);	// Idle after reset
		end
		// Fill pair A with overlapping runs that leave holes
		ldPos = 1'b1;
		palLd = 1'b1;
		pbus  = 24'($urandom());
		nextCycle();
		repeat (400)
		begin
			mixActivity(1'b1, 1'b0, 1'b0);
			nextCycle();
		end
		tms0 = 1'b0;
		displayLine(1'b0, 1'b0, 1'b0, 1'b0);
		displayLine(1'b1, 1'b0, 1'b0, 1'b1);	// Pair A again and now empty
		tms0 = 1'b1;
		displayLine(1'b1, 1'b1, 1'b0, 1'b0);	// Pair B under the fix layer
		tms0 = 1'b0;
		displayLine(1'b0, 1'b1, 1'b1, 1'b0);
		// Watchdog
		countUntilReset(1'b1, WDG_PULSE + 2, waitCnt);
		driveKick();
		nextCycle();
		repeat (4)
		begin
			repeat ($urandom_range(1, WDG_LIMIT - 2))
				nextCycle();
			compareValue("nReset", 32'(nReset), 32'd1);
			driveKick();
			nextCycle();
		end
		countUntilReset(1'b0, WDG_LIMIT + 10, waitCnt);
		compareValue("nReset delay", 32'(waitCnt), 32'(WDG_LIMIT));
		countUntilReset(1'b1, WDG_PULSE + 10, waitCnt);
		compareValue("nReset pulse", 32'(waitCnt), 32'(WDG_PULSE));
		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/b1Pkg.sv
lineBuffer/lineBuffer.sv
lineBuffer/lineBufferBank.sv
logic/fixPixelLatch.sv
logic/paletteAddressMux.sv
logic/watchdog.sv
logic/neoB1.sv
dv/clockGen.sv
dv/tbNeoB1.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal \
	-f verilog.f --top-module tbNeoB1 -o simNeoB1

./obj_dir/simNeoB1 > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
